// File: compile.f
kotku_pkg.sv
wb_bus_if.sv
wb_decoder.sv
flash_ctrl.sv
sram_ctrl.sv
leds_sw.sv
kotku.sv
mem_models.sv
test_kotku.sv
+incdir+.

// File: flash_ctrl.sv
// Boot flash word reader

`timescale 1ns/10ps
`default_nettype none
`include "kotku_consts.svh"

module flash_ctrl (
  input  wire logic                  clk_50,
  input  wire logic                  rst_n,
  wb_bus_if.slave                    bus,
  output kotku_pkg::flash_adr_t      flash_addr,
  input  wire kotku_pkg::flash_dat_t flash_data,
  output logic                       flash_oe_n,
  output logic                       flash_rst_n
);

  import kotku_pkg::*;

  localparam logic [3:0] last_cnt = 4'(`KOTKU_FLASH_WAIT - 1);

  flash_state_e state;
  logic [3:0]   wait_cnt;
  flash_dat_t   lo_byte;
  wb_dat_t      rd_data;
  logic         ack;
  logic         req;

  assign req       = bus.cyc && bus.stb;
  assign bus.ack   = ack;
  assign bus.dat_r = rd_data;

  // flash comes out of reset one clock after the board
  always_ff @(posedge clk_50)
    flash_rst_n <= rst_n;

  always_ff @(posedge clk_50)
  begin
    if (!rst_n)
    begin
      state      <= flash_idle;
      wait_cnt   <= '0;
      ack        <= 1'b0;
      flash_oe_n <= 1'b1;
    end
    else
    begin
      case (state)
        flash_idle:
        begin
          if (req)
          begin
            if (bus.we)
            begin
              // read-only part so the cycle just completes
              ack   <= 1'b1;
              state <= flash_ack;
            end
            else
            begin
              // word w is bytes 2w and 2w+1 within the region
              flash_addr <= {3'b000, bus.adr[17:0], 1'b0};
              flash_oe_n <= 1'b0;
              wait_cnt   <= '0;
              state      <= flash_lo;
            end
          end
        end
        flash_lo:
        begin
          wait_cnt <= wait_cnt + 4'd1;
          if (wait_cnt == last_cnt)
          begin
            lo_byte       <= flash_data;
            flash_addr[0] <= 1'b1;
            wait_cnt      <= '0;
            state         <= flash_hi;
          end
        end
        flash_hi:
        begin
          wait_cnt <= wait_cnt + 4'd1;
          if (wait_cnt == last_cnt)
          begin
            rd_data    <= {flash_data, lo_byte};
            flash_oe_n <= 1'b1;
            ack        <= 1'b1;
            state      <= flash_ack;
          end
        end
        flash_ack:
        begin
          ack   <= 1'b0;
          state <= flash_idle;
        end
        default:
          state <= flash_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: kotku.sv
// Kotku board memory and I/O top

`timescale 1ns/10ps
`default_nettype none

module kotku (
  input  wire logic                  clk_50,
  input  wire logic                  rst_n,
  // wishbone host bus
  input  wire kotku_pkg::wb_adr_t    wb_adr,
  input  wire kotku_pkg::wb_dat_t    wb_dat_w,
  output kotku_pkg::wb_dat_t         wb_dat_r,
  input  wire kotku_pkg::wb_sel_t    wb_sel,
  input  wire logic                  wb_we,
  input  wire logic                  wb_cyc,
  input  wire logic                  wb_stb,
  output logic                       wb_ack,
  // board i/o
  input  wire logic [9:0]            sw,
  output logic      [9:0]            ledr,
  output logic      [7:0]            ledg,
  // boot flash
  output kotku_pkg::flash_adr_t      flash_addr,
  input  wire kotku_pkg::flash_dat_t flash_data,
  output logic                       flash_oe_n,
  output logic                       flash_rst_n,
  // sram
  output kotku_pkg::sram_adr_t       sram_addr,
  output kotku_pkg::wb_dat_t         sram_data_out,
  input  wire kotku_pkg::wb_dat_t    sram_data_in,
  output logic                       sram_data_oe,
  output logic                       sram_we_n,
  output logic                       sram_oe_n,
  output logic                       sram_ce_n,
  output kotku_pkg::wb_sel_t         sram_bw_n
);

  wb_bus_if host_bus ();
  wb_bus_if sram_bus ();
  wb_bus_if flash_bus ();
  wb_bus_if io_bus ();

  assign host_bus.adr   = wb_adr;
  assign host_bus.dat_w = wb_dat_w;
  assign host_bus.sel   = wb_sel;
  assign host_bus.we    = wb_we;
  assign host_bus.cyc   = wb_cyc;
  assign host_bus.stb   = wb_stb;
  assign wb_dat_r       = host_bus.dat_r;
  assign wb_ack         = host_bus.ack;

  wb_decoder wb_decoder_inst (
    .clk_50    (clk_50),
    .rst_n     (rst_n),
    .host      (host_bus.slave),
    .sram_bus  (sram_bus.master),
    .flash_bus (flash_bus.master),
    .io_bus    (io_bus.master)
  );

  flash_ctrl flash_ctrl_inst (
    .clk_50      (clk_50),
    .rst_n       (rst_n),
    .bus         (flash_bus.slave),
    .flash_addr  (flash_addr),
    .flash_data  (flash_data),
    .flash_oe_n  (flash_oe_n),
    .flash_rst_n (flash_rst_n)
  );

  sram_ctrl sram_ctrl_inst (
    .clk_50        (clk_50),
    .rst_n         (rst_n),
    .bus           (sram_bus.slave),
    .sram_addr     (sram_addr),
    .sram_data_out (sram_data_out),
    .sram_data_in  (sram_data_in),
    .sram_data_oe  (sram_data_oe),
    .sram_we_n     (sram_we_n),
    .sram_oe_n     (sram_oe_n),
    .sram_ce_n     (sram_ce_n),
    .sram_bw_n     (sram_bw_n)
  );

  leds_sw leds_sw_inst (
    .clk_50 (clk_50),
    .rst_n  (rst_n),
    .bus    (io_bus.slave),
    .sw     (sw),
    .ledr   (ledr),
    .ledg   (ledg)
  );

endmodule

`default_nettype wire

// File: kotku_consts.svh
// Kotku board constants

`ifndef KOTKU_CONSTS_SVH
`define KOTKU_CONSTS_SVH

// clocks of flash output enable per byte
`define KOTKU_FLASH_WAIT 3

// clocks of each sram ce_n/oe_n/we_n strobe
`define KOTKU_SRAM_WAIT 2

// region codes from word address bits 19:18
// code 3 is left unmapped
`define KOTKU_REG_SRAM  2'd0
`define KOTKU_REG_FLASH 2'd1
`define KOTKU_REG_IO    2'd2

// io word offsets in the low two address bits
`define KOTKU_IO_LEDR 2'd0
`define KOTKU_IO_LEDG 2'd1
`define KOTKU_IO_SW   2'd2

// read value of the unmapped region
`define KOTKU_UNMAPPED_DATA 16'hffff

`endif

// File: kotku_pkg.sv
// Kotku bus and memory types

`default_nettype none

package kotku_pkg;

  // wishbone side, word addressed
  typedef logic [19:0] wb_adr_t;
  typedef logic [15:0] wb_dat_t;
  typedef logic [1:0]  wb_sel_t;

  // external memories
  typedef logic [17:0] sram_adr_t;
  typedef logic [21:0] flash_adr_t;
  typedef logic [7:0]  flash_dat_t;

  // flash reads two bytes per wishbone word
  typedef enum logic [1:0] {
    flash_idle,
    flash_lo,
    flash_hi,
    flash_ack
  } flash_state_e;

  typedef enum logic [1:0] {
    sram_idle,
    sram_read,
    sram_write,
    sram_ack
  } sram_state_e;

endpackage

`default_nettype wire

// File: leds_sw.sv
// LED and switch I/O block

`timescale 1ns/10ps
`default_nettype none
`include "kotku_consts.svh"

module leds_sw (
  input  wire logic       clk_50,
  input  wire logic       rst_n,
  wb_bus_if.slave         bus,
  input  wire logic [9:0] sw,
  output logic      [9:0] ledr,
  output logic      [7:0] ledg
);

  logic [9:0] sw_meta;
  logic [9:0] sw_sync;
  logic       ack;
  logic       wr;

  assign wr      = bus.cyc && bus.stb && bus.we && !ack;
  assign bus.ack = ack;

  // two-flop synchronizer for the board switches
  always_ff @(posedge clk_50)
  begin
    sw_meta <= sw;
    sw_sync <= sw_meta;
  end

  always_ff @(posedge clk_50)
  begin
    if (!rst_n)
    begin
      ack  <= 1'b0;
      ledr <= '0;
      ledg <= '0;
    end
    else
    begin
      ack <= bus.cyc && bus.stb && !ack;
      if (wr && bus.adr[1:0] == `KOTKU_IO_LEDR)
      begin
        if (bus.sel[0])
          ledr[7:0] <= bus.dat_w[7:0];
        if (bus.sel[1])
          ledr[9:8] <= bus.dat_w[9:8];
      end
      if (wr && bus.adr[1:0] == `KOTKU_IO_LEDG && bus.sel[0])
        ledg <= bus.dat_w[7:0];
    end
  end

  always_comb
  begin
    case (bus.adr[1:0])
      `KOTKU_IO_LEDR: bus.dat_r = {6'd0, ledr};
      `KOTKU_IO_LEDG: bus.dat_r = {8'd0, ledg};
      `KOTKU_IO_SW:   bus.dat_r = {6'd0, sw_sync};
      default:        bus.dat_r = 16'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: mem_models.sv
// Behavioral board memories

`timescale 1ns/10ps
`default_nettype none

module flash_model (
  input  wire logic [21:0] flash_addr,
  input  wire logic        flash_oe_n,
  input  wire logic        flash_rst_n,
  output logic      [7:0]  flash_data
);

  logic [7:0] mem [0:65535];

  // boot image pattern from the low and middle address bytes
  initial
  begin
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
  end

  // only the low 64K bytes are populated
  assign flash_data = (flash_oe_n || !flash_rst_n) ? 8'hff : mem[flash_addr[15:0]];

endmodule

module sram_model (
  input  wire logic        clk,
  input  wire logic [17:0] addr,
  input  wire logic [15:0] wr_data,
  output logic      [15:0] rd_data,
  input  wire logic        data_oe,
  input  wire logic        we_n,
  input  wire logic        oe_n,
  input  wire logic        ce_n,
  input  wire logic [1:0]  bw_n
);

  logic [15:0] mem [0:262143];

  initial
  begin
    for (int i = 0; i < 262144; i++)
      mem[i] = 16'(i ^ (i >> 16));
  end

  // write strobe sampled on the board clock
  always @(posedge clk)
  begin
    if (!ce_n && !we_n && data_oe)
    begin
      if (!bw_n[0])
        mem[addr][7:0] <= wr_data[7:0];
      if (!bw_n[1])
        mem[addr][15:8] <= wr_data[15:8];
    end
  end

  // disabled lanes read back as zero
  assign rd_data = (!ce_n && !oe_n) ?
                   {bw_n[1] ? 8'h00 : mem[addr][15:8], bw_n[0] ? 8'h00 : mem[addr][7:0]} :
                   16'h0000;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the kotku testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module test_kotku \
  -Mdir obj_dir -o sim_kotku
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_kotku > sim.log 2>&1
status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0

// File: sram_ctrl.sv
// Asynchronous SRAM controller

`timescale 1ns/10ps
`default_nettype none
`include "kotku_consts.svh"

module sram_ctrl (
  input  wire logic               clk_50,
  input  wire logic               rst_n,
  wb_bus_if.slave                 bus,
  output kotku_pkg::sram_adr_t    sram_addr,
  output kotku_pkg::wb_dat_t      sram_data_out,
  input  wire kotku_pkg::wb_dat_t sram_data_in,
  output logic                    sram_data_oe,
  output logic                    sram_we_n,
  output logic                    sram_oe_n,
  output logic                    sram_ce_n,
  output kotku_pkg::wb_sel_t      sram_bw_n
);

  import kotku_pkg::*;

  localparam logic [3:0] last_cnt = 4'(`KOTKU_SRAM_WAIT - 1);

  sram_state_e state;
  logic [3:0]  wait_cnt;
  wb_dat_t     rd_data;
  logic        ack;

  assign bus.ack   = ack;
  assign bus.dat_r = rd_data;

  always_ff @(posedge clk_50)
  begin
    if (!rst_n)
    begin
      state        <= sram_idle;
      wait_cnt     <= '0;
      ack          <= 1'b0;
      sram_ce_n    <= 1'b1;
      sram_oe_n    <= 1'b1;
      sram_we_n    <= 1'b1;
      sram_bw_n    <= 2'b11;
      sram_data_oe <= 1'b0;
    end
    else
    begin
      case (state)
        sram_idle:
        begin
          if (bus.cyc && bus.stb)
          begin
            sram_addr     <= bus.adr[17:0];
            sram_data_out <= bus.dat_w;
            // reads always fetch both lanes
            sram_bw_n     <= bus.we ? ~bus.sel : 2'b00;
            sram_ce_n     <= 1'b0;
            sram_oe_n     <= bus.we;
            sram_we_n     <= !bus.we;
            sram_data_oe  <= bus.we;
            wait_cnt      <= '0;
            state         <= bus.we ? sram_write : sram_read;
          end
        end
        sram_read, sram_write:
        begin
          wait_cnt <= wait_cnt + 4'd1;
          if (wait_cnt == last_cnt)
          begin
            // read data has settled by the last strobe cycle
            if (state == sram_read)
              rd_data <= sram_data_in;
            sram_ce_n    <= 1'b1;
            sram_oe_n    <= 1'b1;
            sram_we_n    <= 1'b1;
            sram_bw_n    <= 2'b11;
            sram_data_oe <= 1'b0;
            ack          <= 1'b1;
            state        <= sram_ack;
          end
        end
        sram_ack:
        begin
          ack   <= 1'b0;
          state <= sram_idle;
        end
        default:
          state <= sram_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: test_kotku.sv
// Kotku memory and I/O testbench

`timescale 1ns/10ps
`default_nettype none
`include "kotku_consts.svh"

module test_kotku;

  import kotku_pkg::*;

  localparam int sram_words  = 8;
  localparam int sram_writes = 24;
  localparam int flash_reads = 16;
  localparam int slowest     = 2 * `KOTKU_FLASH_WAIT + 2;
  localparam int ack_limit   = 4 * slowest;
  localparam int num_xfers   = 2 * sram_words + sram_writes + flash_reads + 32;
  localparam int watchdog_cycles = num_xfers * (slowest + 3) + 20;

  logic       clk_50 = 1'b0;
  logic       rst_n;
  wb_adr_t    wb_adr;
  wb_dat_t    wb_dat_w;
  wb_dat_t    wb_dat_r;
  wb_sel_t    wb_sel;
  logic       wb_we;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_ack;
  logic [9:0] sw;
  logic [9:0] ledr;
  logic [7:0] ledg;
  flash_adr_t flash_addr;
  flash_dat_t flash_data;
  logic       flash_oe_n;
  logic       flash_rst_n;
  sram_adr_t  sram_addr;
  wb_dat_t    sram_data_out;
  wb_dat_t    sram_data_in;
  logic       sram_data_oe;
  logic       sram_we_n;
  logic       sram_oe_n;
  logic       sram_ce_n;
  wb_sel_t    sram_bw_n;

  integer      seed;
  logic [31:0] rnd;
  wb_dat_t     rd;
  int          lat;
  sram_adr_t   addrs [sram_words];
  wb_dat_t     sram_copy [sram_words];
  logic [14:0] last_w;
  wb_dat_t     last_flash;
  logic [9:0]  ledr_exp;
  logic [7:0]  ledg_exp;

  always #4 clk_50 = ~clk_50;

  kotku kotku_inst (
    .clk_50        (clk_50),
    .rst_n         (rst_n),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_sel        (wb_sel),
    .wb_we         (wb_we),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack),
    .sw            (sw),
    .ledr          (ledr),
    .ledg          (ledg),
    .flash_addr    (flash_addr),
    .flash_data    (flash_data),
    .flash_oe_n    (flash_oe_n),
    .flash_rst_n   (flash_rst_n),
    .sram_addr     (sram_addr),
    .sram_data_out (sram_data_out),
    .sram_data_in  (sram_data_in),
    .sram_data_oe  (sram_data_oe),
    .sram_we_n     (sram_we_n),
    .sram_oe_n     (sram_oe_n),
    .sram_ce_n     (sram_ce_n),
    .sram_bw_n     (sram_bw_n)
  );

  flash_model flash_model_inst (
    .flash_addr  (flash_addr),
    .flash_oe_n  (flash_oe_n),
    .flash_rst_n (flash_rst_n),
    .flash_data  (flash_data)
  );

  sram_model sram_model_inst (
    .clk     (clk_50),
    .addr    (sram_addr),
    .wr_data (sram_data_out),
    .rd_data (sram_data_in),
    .data_oe (sram_data_oe),
    .we_n    (sram_we_n),
    .oe_n    (sram_oe_n),
    .ce_n    (sram_ce_n),
    .bw_n    (sram_bw_n)
  );

  task automatic report_error(input string msg);
    $display("FAIL at time %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string what, input wb_dat_t got, input wb_dat_t exp);
    assert (got == exp)
    else
      report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_cycles(input string what, input int got, input int exp);
    assert (got == exp)
    else
      report_error($sformatf("%s: ack after %0d cycles, expected %0d", what, got, exp));
  endtask

  // ack is never seen outside an active cycle
  ack_in_cycle: assert property (@(posedge clk_50) disable iff (!rst_n)
                                 wb_ack |-> (wb_cyc && wb_stb))
  else
    report_error("ack high outside an active bus cycle");

  // expected flash byte at a byte address
  function automatic flash_dat_t flash_byte(input logic [15:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  function automatic wb_adr_t io_adr(input logic [1:0] off);
    return {`KOTKU_REG_IO, 16'h0000, off};
  endfunction

  // classic cycle with clocks counted from the first stb edge to ack
  task automatic wb_transfer(input wb_adr_t adr, input logic we, input wb_dat_t dat,
                             input wb_sel_t sel, output wb_dat_t rdata, output int cycles);
    int n;
    n = 0;
    @(posedge clk_50);
    #1;
    wb_adr   = adr;
    wb_we    = we;
    wb_dat_w = dat;
    wb_sel   = sel;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    @(posedge clk_50);
    do
    begin
      @(negedge clk_50);
      n++;
    end
    while (!wb_ack && n < ack_limit);
    assert (wb_ack)
    else
      report_error($sformatf("no ack for address %h", adr));
    rdata  = wb_dat_r;
    cycles = n;
    @(posedge clk_50);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk_50);
    assert (!wb_ack)
    else
      report_error("ack held for more than one cycle");
  endtask

  task automatic sram_tests();
    int idx;
    wb_dat_t d;
    wb_sel_t s;
    // distinct low bits keep the words apart
    for (int i = 0; i < sram_words; i++)
    begin
      rnd = $random(seed);
      addrs[i] = {rnd[17:3], 3'(i)};
      d = rnd[31:16];
      wb_transfer({`KOTKU_REG_SRAM, addrs[i]}, 1'b1, d, 2'b11, rd, lat);
      check_cycles("sram full write", lat, `KOTKU_SRAM_WAIT + 1);
      sram_copy[i] = d;
    end
    for (int i = 0; i < sram_writes; i++)
    begin
      rnd = $random(seed);
      idx = int'(rnd[2:0]);
      s = rnd[5:4];
      d = rnd[31:16];
      wb_transfer({`KOTKU_REG_SRAM, addrs[idx]}, 1'b1, d, s, rd, lat);
      check_cycles("sram lane write", lat, `KOTKU_SRAM_WAIT + 1);
      if (s[0])
        sram_copy[idx][7:0] = d[7:0];
      if (s[1])
        sram_copy[idx][15:8] = d[15:8];
    end
    for (int i = 0; i < sram_words; i++)
    begin
      wb_transfer({`KOTKU_REG_SRAM, addrs[i]}, 1'b0, 16'h0000, 2'b11, rd, lat);
      check_cycles("sram read", lat, `KOTKU_SRAM_WAIT + 1);
      check_word("sram read data", rd, sram_copy[i]);
    end
  endtask

  task automatic flash_tests();
    for (int i = 0; i < flash_reads; i++)
    begin
      rnd = $random(seed);
      last_w = rnd[14:0];
      last_flash = {flash_byte({last_w, 1'b1}), flash_byte({last_w, 1'b0})};
      wb_transfer({`KOTKU_REG_FLASH, 3'b000, last_w}, 1'b0, 16'h0000, 2'b11, rd, lat);
      check_word("flash read data", rd, last_flash);
    end
    // writes complete but the part stays unchanged
    wb_transfer({`KOTKU_REG_FLASH, 3'b000, last_w}, 1'b1, ~last_flash, 2'b11, rd, lat);
    check_cycles("flash write", lat, 1);
    wb_transfer({`KOTKU_REG_FLASH, 3'b000, last_w}, 1'b0, 16'h0000, 2'b11, rd, lat);
    check_word("flash read after write", rd, last_flash);
  endtask

  task automatic io_tests();
    wb_dat_t d;
    for (int k = 3; k >= 0; k--)
    begin
      rnd = $random(seed);
      d = rnd[15:0];
      wb_transfer(io_adr(`KOTKU_IO_LEDR), 1'b1, d, 2'(k), rd, lat);
      check_cycles("ledr write", lat, 1);
      if (k[0])
        ledr_exp[7:0] = d[7:0];
      if (k[1])
        ledr_exp[9:8] = d[9:8];
      check_word("ledr port", {6'd0, ledr}, {6'd0, ledr_exp});
      wb_transfer(io_adr(`KOTKU_IO_LEDR), 1'b0, 16'h0000, 2'b11, rd, lat);
      check_word("ledr read", rd, {6'd0, ledr_exp});
    end
    for (int k = 3; k >= 0; k--)
    begin
      rnd = $random(seed);
      d = rnd[15:0];
      wb_transfer(io_adr(`KOTKU_IO_LEDG), 1'b1, d, 2'(k), rd, lat);
      if (k[0])
        ledg_exp = d[7:0];
      check_word("ledg port", {8'd0, ledg}, {8'd0, ledg_exp});
      wb_transfer(io_adr(`KOTKU_IO_LEDG), 1'b0, 16'h0000, 2'b11, rd, lat);
      check_cycles("ledg read", lat, 1);
      check_word("ledg read", rd, {8'd0, ledg_exp});
    end
    rnd = $random(seed);
    @(posedge clk_50);
    #1;
    sw = rnd[9:0];
    repeat (2) @(posedge clk_50);
    wb_transfer(io_adr(`KOTKU_IO_SW), 1'b0, 16'h0000, 2'b11, rd, lat);
    check_word("switch read", rd, {6'd0, sw});
  endtask

  task automatic unmapped_tests();
    for (int i = 0; i < 4; i++)
    begin
      rnd = $random(seed);
      wb_transfer({2'b11, rnd[17:0]}, 1'b0, 16'h0000, 2'b11, rd, lat);
      check_cycles("unmapped read", lat, 1);
      check_word("unmapped read data", rd, `KOTKU_UNMAPPED_DATA);
    end
    // same low bits as the io, sram and flash words
    wb_transfer({2'b11, 16'h0000, `KOTKU_IO_LEDR}, 1'b1, 16'h03ff, 2'b11, rd, lat);
    wb_transfer({2'b11, 16'h0000, `KOTKU_IO_LEDG}, 1'b1, 16'h00ff, 2'b11, rd, lat);
    check_word("ledr after unmapped write", {6'd0, ledr}, {6'd0, ledr_exp});
    check_word("ledg after unmapped write", {8'd0, ledg}, {8'd0, ledg_exp});
    wb_transfer({2'b11, addrs[0]}, 1'b1, ~sram_copy[0], 2'b11, rd, lat);
    wb_transfer({2'b11, 3'b000, last_w}, 1'b1, ~last_flash, 2'b11, rd, lat);
    wb_transfer({`KOTKU_REG_SRAM, addrs[0]}, 1'b0, 16'h0000, 2'b11, rd, lat);
    check_word("sram after unmapped write", rd, sram_copy[0]);
    wb_transfer({`KOTKU_REG_FLASH, 3'b000, last_w}, 1'b0, 16'h0000, 2'b11, rd, lat);
    check_word("flash after unmapped write", rd, last_flash);
  endtask

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk_50);
    $display("simulation did not finish within %0d clock cycles", watchdog_cycles);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog timeout");
  end

  initial
  begin
    seed = 32'hbbec;
    rst_n = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    wb_we = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    sw = '0;
    ledr_exp = '0;
    ledg_exp = '0;
    repeat (5) @(posedge clk_50);
    #1;
    assert (!flash_rst_n)
    else
      report_error("flash_rst_n high during reset");
    rst_n = 1'b1;
    @(negedge clk_50);
    assert (!wb_ack && ledr == 10'd0 && ledg == 8'd0)
    else
      report_error("bus or led outputs not at reset values");
    assert (sram_ce_n && sram_oe_n && sram_we_n && sram_bw_n == 2'b11 && !sram_data_oe)
    else
      report_error("sram strobes not idle after reset");
    assert (flash_oe_n && !flash_rst_n)
    else
      report_error("flash pins not at reset values");
    @(posedge clk_50);
    #1;
    assert (flash_rst_n)
    else
      report_error("flash_rst_n did not rise one cycle after reset");
    sram_tests();
    flash_tests();
    io_tests();
    unmapped_tests();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_bus_if.sv
// Wishbone classic bus

`timescale 1ns/10ps
`default_nettype none

interface wb_bus_if;

  import kotku_pkg::*;

  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_dat_t dat_r;
  wb_sel_t sel;
  logic    we;
  logic    cyc;
  logic    stb;
  logic    ack;

  modport master (
    output adr,
    output dat_w,
    output sel,
    output we,
    output cyc,
    output stb,
    input  dat_r,
    input  ack
  );

  modport slave (
    input  adr,
    input  dat_w,
    input  sel,
    input  we,
    input  cyc,
    input  stb,
    output dat_r,
    output ack
  );

endinterface

`default_nettype wire

// File: wb_decoder.sv
// Wishbone region decoder

`timescale 1ns/10ps
`default_nettype none
`include "kotku_consts.svh"

module wb_decoder (
  input wire logic clk_50,
  input wire logic rst_n,
  wb_bus_if.slave  host,
  wb_bus_if.master sram_bus,
  wb_bus_if.master flash_bus,
  wb_bus_if.master io_bus
);

  logic [1:0] region;
  logic       unm_ack;

  assign region = host.adr[19:18];

  // shared fields go to every slave
  assign sram_bus.adr    = host.adr;
  assign sram_bus.dat_w  = host.dat_w;
  assign sram_bus.sel    = host.sel;
  assign sram_bus.we     = host.we;
  assign sram_bus.cyc    = host.cyc;
  assign flash_bus.adr   = host.adr;
  assign flash_bus.dat_w = host.dat_w;
  assign flash_bus.sel   = host.sel;
  assign flash_bus.we    = host.we;
  assign flash_bus.cyc   = host.cyc;
  assign io_bus.adr      = host.adr;
  assign io_bus.dat_w    = host.dat_w;
  assign io_bus.sel      = host.sel;
  assign io_bus.we       = host.we;
  assign io_bus.cyc      = host.cyc;

  // only the selected slave sees stb
  assign sram_bus.stb  = host.stb && (region == `KOTKU_REG_SRAM);
  assign flash_bus.stb = host.stb && (region == `KOTKU_REG_FLASH);
  assign io_bus.stb    = host.stb && (region == `KOTKU_REG_IO);

  // unmapped region answers by itself after one clock
  always_ff @(posedge clk_50)
  begin
    if (!rst_n)
      unm_ack <= 1'b0;
    else
      unm_ack <= host.cyc && host.stb && (region == 2'd3) && !unm_ack;
  end

  always_comb
  begin
    case (region)
      `KOTKU_REG_SRAM:
      begin
        host.ack   = sram_bus.ack;
        host.dat_r = sram_bus.dat_r;
      end
      `KOTKU_REG_FLASH:
      begin
        host.ack   = flash_bus.ack;
        host.dat_r = flash_bus.dat_r;
      end
      `KOTKU_REG_IO:
      begin
        host.ack   = io_bus.ack;
        host.dat_r = io_bus.dat_r;
      end
      default:
      begin
        host.ack   = unm_ack;
        host.dat_r = `KOTKU_UNMAPPED_DATA;
      end
    endcase
  end

endmodule

`default_nettype wire
